//--- include/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4

// local device map, everything else goes out on the external port
`define BUS_SERIAL_ADDR 32'ha000_03f8

// timer words, low word must sit on an 8-byte boundary
`define BUS_RTC_ADDR 32'ha000_0048
`define BUS_RTC_ADDR_UP (`BUS_RTC_ADDR + 32'h4)

`endif

//--- logic/bus_pkg.sv
package bus_pkg;

  // response codes as on the external port
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } bus_resp_e;

  // current grant holder
  typedef enum logic [1:0] {
    NONE   = 2'd0,
    IFU_RD = 2'd1,
    LSU_RD = 2'd2,
    LSU_WR = 2'd3
  } bus_owner_e;

  // arbiter states, one per busy requester kind
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    BUSY_IFU    = 2'd1,
    BUSY_LSU_RD = 2'd2,
    BUSY_LSU_WR = 2'd3
  } arb_state_e;

endpackage

//--- logic/dev_pkg.sv
`include "bus_cfg.svh"

package dev_pkg;

  // transaction target after address decode
  typedef enum logic [1:0] {
    DEV_MEM   = 2'd0,
    DEV_CLINT = 2'd1,
    DEV_UART  = 2'd2
  } dev_sel_e;

  // only the two timer words are served locally on reads
  function automatic dev_sel_e dev_rd_target(input logic [`BUS_ADDR_W-1:0] addr);
    return ((addr == `BUS_RTC_ADDR) || (addr == `BUS_RTC_ADDR_UP)) ? DEV_CLINT : DEV_MEM;
  endfunction

  // serial port is write only
  function automatic dev_sel_e dev_wr_target(input logic [`BUS_ADDR_W-1:0] addr);
    return (addr == `BUS_SERIAL_ADDR) ? DEV_UART : DEV_MEM;
  endfunction

endpackage

//--- logic/bus_rd_if.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

interface bus_rd_if;
  // address channel
  logic [`BUS_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;

  // read data channel
  logic [`BUS_DATA_W-1:0] rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport slave (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );
endinterface

//--- logic/bus_wr_if.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

interface bus_wr_if;
  // write address channel
  logic [`BUS_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;

  // write data channel
  logic [`BUS_DATA_W-1:0] wdata;
  logic [`BUS_STRB_W-1:0] wstrb;
  logic                   wvalid;
  logic                   wready;

  // write response channel
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );
endinterface

//--- logic/bus_arbiter_fsm.sv
`timescale 1ns/1ps

module bus_arbiter_fsm
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ifu_arvalid_i,
  input  logic       lsu_arvalid_i,
  input  logic       lsu_awvalid_i,
  input  logic       done_i,
  output bus_owner_e owner_o
);

  arb_state_e state_q;
  arb_state_e state_d;

  // fixed priority: store, then load, then fetch
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (lsu_awvalid_i) begin
          state_d = BUSY_LSU_WR;
        end else if (lsu_arvalid_i) begin
          state_d = BUSY_LSU_RD;
        end else if (ifu_arvalid_i) begin
          state_d = BUSY_IFU;
        end
      end
      BUSY_IFU,
      BUSY_LSU_RD,
      BUSY_LSU_WR: begin
        // grant is held through back-pressure until the response is taken
        if (done_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // owner follows the state register directly
  always_comb begin
    unique case (state_q)
      BUSY_IFU:    owner_o = IFU_RD;
      BUSY_LSU_RD: owner_o = LSU_RD;
      BUSY_LSU_WR: owner_o = LSU_WR;
      default:     owner_o = NONE;
    endcase
  end

endmodule

//--- logic/bus_clint.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_clint
  import bus_pkg::*;
(
  input logic     clk,
  input logic     rst,
  bus_rd_if.slave rd
);

  logic [63:0]            mtime_q;
  logic                   rvalid_q;
  logic [`BUS_DATA_W-1:0] rdata_q;
  logic                   ar_fire;
  logic                   r_fire;

  assign ar_fire = rd.arvalid & rd.arready;
  assign r_fire  = rd.rvalid & rd.rready;

  // free running machine timer
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= 64'd0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (r_fire) begin
      rvalid_q <= 1'b0;
    end
  end

  // bit 2 picks the high word
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= rd.araddr[2] ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  // one response slot
  assign rd.arready = ~rvalid_q;
  assign rd.rvalid  = rvalid_q;
  assign rd.rdata   = rdata_q;
  assign rd.rresp   = OKAY;

endmodule

//--- logic/bus_uart_tx.sv
`timescale 1ns/1ps

module bus_uart_tx
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  bus_wr_if.slave    wr,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o
);

  logic      bvalid_q;
  logic      accept;

  // address and data are taken on the same edge
  assign accept = wr.awvalid & wr.wvalid & ~bvalid_q;

  assign wr.awready = accept;
  assign wr.wready  = accept;

  // strobe only when byte lane 0 carries data
  assign tx_valid_o = accept & wr.wstrb[0];
  assign tx_data_o  = wr.wdata[7:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid_q <= 1'b0;
    end else if (accept) begin
      bvalid_q <= 1'b1;
    end else if (wr.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  assign wr.bvalid = bvalid_q;
  assign wr.bresp  = OKAY;

endmodule

//--- logic/bus_xbar.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_xbar
  import bus_pkg::*, dev_pkg::*;
(
  input  bus_owner_e             owner_i,
  output logic                   done_o,
  // fetch read
  input  logic [`BUS_ADDR_W-1:0] ifu_araddr_i,
  input  logic                   ifu_arvalid_i,
  output logic                   ifu_arready_o,
  output logic [`BUS_DATA_W-1:0] ifu_rdata_o,
  output logic [1:0]             ifu_rresp_o,
  output logic                   ifu_rvalid_o,
  input  logic                   ifu_rready_i,
  // load
  input  logic [`BUS_ADDR_W-1:0] lsu_araddr_i,
  input  logic                   lsu_arvalid_i,
  output logic                   lsu_arready_o,
  output logic [`BUS_DATA_W-1:0] lsu_rdata_o,
  output logic [1:0]             lsu_rresp_o,
  output logic                   lsu_rvalid_o,
  input  logic                   lsu_rready_i,
  // store
  input  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i,
  input  logic                   lsu_awvalid_i,
  output logic                   lsu_awready_o,
  input  logic [`BUS_DATA_W-1:0] lsu_wdata_i,
  input  logic [`BUS_STRB_W-1:0] lsu_wstrb_i,
  input  logic                   lsu_wvalid_i,
  output logic                   lsu_wready_o,
  output logic [1:0]             lsu_bresp_o,
  output logic                   lsu_bvalid_o,
  input  logic                   lsu_bready_i,
  // external AXI-lite master
  output logic [`BUS_ADDR_W-1:0] m_araddr_o,
  output logic                   m_arvalid_o,
  input  logic                   m_arready_i,
  input  logic [`BUS_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]             m_rresp_i,
  input  logic                   m_rvalid_i,
  output logic                   m_rready_o,
  output logic [`BUS_ADDR_W-1:0] m_awaddr_o,
  output logic                   m_awvalid_o,
  input  logic                   m_awready_i,
  output logic [`BUS_DATA_W-1:0] m_wdata_o,
  output logic [`BUS_STRB_W-1:0] m_wstrb_o,
  output logic                   m_wvalid_o,
  input  logic                   m_wready_i,
  input  logic [1:0]             m_bresp_i,
  input  logic                   m_bvalid_i,
  output logic                   m_bready_o,
  // local devices
  bus_rd_if.master               clint_rd,
  bus_wr_if.master               uart_wr
);

  logic                   ifu_own;
  logic                   lsu_rd_own;
  logic                   lsu_wr_own;
  dev_sel_e               rd_sel;
  dev_sel_e               wr_sel;
  logic [`BUS_ADDR_W-1:0] ar_addr;
  logic                   ar_valid;
  logic                   ar_ready;
  logic                   r_valid;
  logic                   r_ready;
  logic [`BUS_DATA_W-1:0] r_data;
  logic [1:0]             r_resp;
  logic                   b_valid;
  logic [1:0]             b_resp;

  assign ifu_own    = (owner_i == IFU_RD);
  assign lsu_rd_own = (owner_i == LSU_RD);
  assign lsu_wr_own = (owner_i == LSU_WR);

  // fetches always go to memory
  assign rd_sel = lsu_rd_own ? dev_rd_target(lsu_araddr_i) : DEV_MEM;
  assign wr_sel = dev_wr_target(lsu_awaddr_i);

  // read request from the owner only
  assign ar_addr  = ifu_own ? ifu_araddr_i : lsu_araddr_i;
  assign ar_valid = (ifu_own & ifu_arvalid_i) | (lsu_rd_own & lsu_arvalid_i);
  assign ar_ready = (rd_sel == DEV_CLINT) ? clint_rd.arready : m_arready_i;

  assign m_araddr_o       = ar_addr;
  assign m_arvalid_o      = ar_valid & (rd_sel == DEV_MEM);
  assign clint_rd.araddr  = ar_addr;
  assign clint_rd.arvalid = ar_valid & (rd_sel == DEV_CLINT);

  assign ifu_arready_o = ifu_own & ar_ready;
  assign lsu_arready_o = lsu_rd_own & ar_ready;

  // only the addressed target can hold a read response
  assign r_valid = clint_rd.rvalid | m_rvalid_i;
  assign r_data  = clint_rd.rvalid ? clint_rd.rdata : m_rdata_i;
  assign r_resp  = clint_rd.rvalid ? clint_rd.rresp : m_rresp_i;
  assign r_ready = (ifu_own & ifu_rready_i) | (lsu_rd_own & lsu_rready_i);

  assign m_rready_o      = r_ready;
  assign clint_rd.rready = r_ready;

  assign ifu_rvalid_o = ifu_own & r_valid;
  assign ifu_rdata_o  = r_data;
  assign ifu_rresp_o  = r_resp;
  assign lsu_rvalid_o = lsu_rd_own & r_valid;
  assign lsu_rdata_o  = r_data;
  assign lsu_rresp_o  = r_resp;

  // write address and data follow the same decode
  assign m_awaddr_o  = lsu_awaddr_i;
  assign m_wdata_o   = lsu_wdata_i;
  assign m_wstrb_o   = lsu_wstrb_i;
  assign m_awvalid_o = lsu_wr_own & lsu_awvalid_i & (wr_sel == DEV_MEM);
  assign m_wvalid_o  = lsu_wr_own & lsu_wvalid_i & (wr_sel == DEV_MEM);

  assign uart_wr.awaddr  = lsu_awaddr_i;
  assign uart_wr.wdata   = lsu_wdata_i;
  assign uart_wr.wstrb   = lsu_wstrb_i;
  assign uart_wr.awvalid = lsu_wr_own & lsu_awvalid_i & (wr_sel == DEV_UART);
  assign uart_wr.wvalid  = lsu_wr_own & lsu_wvalid_i & (wr_sel == DEV_UART);

  assign lsu_awready_o = lsu_wr_own &
                         ((wr_sel == DEV_UART) ? uart_wr.awready : m_awready_i);
  assign lsu_wready_o  = lsu_wr_own &
                         ((wr_sel == DEV_UART) ? uart_wr.wready : m_wready_i);

  // write response, again from whichever side answered
  assign b_valid = uart_wr.bvalid | m_bvalid_i;
  assign b_resp  = uart_wr.bvalid ? uart_wr.bresp : m_bresp_i;

  assign m_bready_o     = lsu_wr_own & lsu_bready_i;
  assign uart_wr.bready = lsu_wr_own & lsu_bready_i;

  assign lsu_bvalid_o = lsu_wr_own & b_valid;
  assign lsu_bresp_o  = b_resp;

  // final handshake of the granted transaction
  assign done_o = (ifu_rvalid_o & ifu_rready_i) |
                  (lsu_rvalid_o & lsu_rready_i) |
                  (lsu_bvalid_o & lsu_bready_i);

endmodule

//--- logic/bus_top.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_top
  import bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // fetch read
  input  logic [`BUS_ADDR_W-1:0] ifu_araddr_i,
  input  logic                   ifu_arvalid_i,
  output logic                   ifu_arready_o,
  output logic [`BUS_DATA_W-1:0] ifu_rdata_o,
  output logic [1:0]             ifu_rresp_o,
  output logic                   ifu_rvalid_o,
  input  logic                   ifu_rready_i,
  // load
  input  logic [`BUS_ADDR_W-1:0] lsu_araddr_i,
  input  logic                   lsu_arvalid_i,
  output logic                   lsu_arready_o,
  output logic [`BUS_DATA_W-1:0] lsu_rdata_o,
  output logic [1:0]             lsu_rresp_o,
  output logic                   lsu_rvalid_o,
  input  logic                   lsu_rready_i,
  // store
  input  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i,
  input  logic                   lsu_awvalid_i,
  output logic                   lsu_awready_o,
  input  logic [`BUS_DATA_W-1:0] lsu_wdata_i,
  input  logic [`BUS_STRB_W-1:0] lsu_wstrb_i,
  input  logic                   lsu_wvalid_i,
  output logic                   lsu_wready_o,
  output logic [1:0]             lsu_bresp_o,
  output logic                   lsu_bvalid_o,
  input  logic                   lsu_bready_i,
  // external AXI-lite master
  output logic [`BUS_ADDR_W-1:0] m_araddr_o,
  output logic                   m_arvalid_o,
  input  logic                   m_arready_i,
  input  logic [`BUS_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]             m_rresp_i,
  input  logic                   m_rvalid_i,
  output logic                   m_rready_o,
  output logic [`BUS_ADDR_W-1:0] m_awaddr_o,
  output logic                   m_awvalid_o,
  input  logic                   m_awready_i,
  output logic [`BUS_DATA_W-1:0] m_wdata_o,
  output logic [`BUS_STRB_W-1:0] m_wstrb_o,
  output logic                   m_wvalid_o,
  input  logic                   m_wready_i,
  input  logic [1:0]             m_bresp_i,
  input  logic                   m_bvalid_i,
  output logic                   m_bready_o,
  // serial transmit strobe
  output logic [7:0]             tx_data_o,
  output logic                   tx_valid_o
);

  bus_owner_e owner;
  logic       done;

  bus_rd_if clint_rd ();
  bus_wr_if uart_wr ();

  bus_arbiter_fsm u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .done_i        (done),
    .owner_o       (owner)
  );

  // port names match one to one
  bus_xbar u_xbar (
    .owner_i  (owner),
    .done_o   (done),
    .clint_rd (clint_rd.master),
    .uart_wr  (uart_wr.master),
    .*
  );

  bus_clint u_clint (
    .clk (clk),
    .rst (rst),
    .rd  (clint_rd.slave)
  );

  bus_uart_tx u_uart_tx (
    .clk        (clk),
    .rst        (rst),
    .wr         (uart_wr.slave),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o)
  );

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module tb_mem_model
  import bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`BUS_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [`BUS_DATA_W-1:0] rdata_o,
  output logic [1:0]             rresp_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  input  logic [`BUS_ADDR_W-1:0] awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [`BUS_DATA_W-1:0] wdata_i,
  input  logic [`BUS_STRB_W-1:0] wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output logic [1:0]             bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i
);

  logic [`BUS_DATA_W-1:0] words [logic [`BUS_ADDR_W-1:0]];
  logic                   busy;

  // unwritten words come from a pattern over the full address
  function automatic logic [`BUS_DATA_W-1:0] fill_word(input logic [`BUS_ADDR_W-1:0] addr);
    return (addr ^ 32'hc3a5_5a3c) + {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [`BUS_DATA_W-1:0] stored_word(input logic [`BUS_ADDR_W-1:0] addr);
    return words.exists(addr) ? words[addr] : fill_word(addr);
  endfunction

  // one transaction at a time, address and data taken together
  assign arready_o = ~busy;
  assign awready_o = ~busy & awvalid_i & wvalid_i;
  assign wready_o  = ~busy & awvalid_i & wvalid_i;

  initial begin
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] word;
    int                     delay;
    busy     = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    rresp_o  = OKAY;
    bvalid_o = 1'b0;
    bresp_o  = OKAY;
    forever begin
      @(negedge clk);
      if (!rst && arvalid_i && arready_o) begin
        addr  = araddr_i;
        delay = $urandom_range(3, 0);
        @(posedge clk);
        #1 busy = 1'b1;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        rdata_o  = stored_word(addr);
        rresp_o  = OKAY;
        rvalid_o = 1'b1;
        do @(negedge clk); while (!rready_i);
        @(posedge clk);
        #1;
        rvalid_o = 1'b0;
        busy     = 1'b0;
      end else if (!rst && awready_o) begin
        word = stored_word(awaddr_i);
        for (int b = 0; b < `BUS_STRB_W; b++) begin
          if (wstrb_i[b]) begin
            word[8*b +: 8] = wdata_i[8*b +: 8];
          end
        end
        words[awaddr_i] = word;
        delay = $urandom_range(3, 0);
        @(posedge clk);
        #1 busy = 1'b1;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        bresp_o  = OKAY;
        bvalid_o = 1'b1;
        do @(negedge clk); while (!bready_i);
        @(posedge clk);
        #1;
        bvalid_o = 1'b0;
        busy     = 1'b0;
      end
    end
  end

endmodule

//--- testbench/tb_bus_top.sv
`timescale 1ns/1ps
`include "bus_cfg.svh"

module tb_bus_top
  import bus_pkg::*;
;

  localparam int TXN_COUNT       = 22;
  localparam int WATCHDOG_CYCLES = TXN_COUNT * 40 + 100;

  logic                   clk;
  logic                   rst;
  logic [`BUS_ADDR_W-1:0] ifu_araddr_i;
  logic                   ifu_arvalid_i;
  logic                   ifu_arready_o;
  logic [`BUS_DATA_W-1:0] ifu_rdata_o;
  logic [1:0]             ifu_rresp_o;
  logic                   ifu_rvalid_o;
  logic                   ifu_rready_i;
  logic [`BUS_ADDR_W-1:0] lsu_araddr_i;
  logic                   lsu_arvalid_i;
  logic                   lsu_arready_o;
  logic [`BUS_DATA_W-1:0] lsu_rdata_o;
  logic [1:0]             lsu_rresp_o;
  logic                   lsu_rvalid_o;
  logic                   lsu_rready_i;
  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i;
  logic                   lsu_awvalid_i;
  logic                   lsu_awready_o;
  logic [`BUS_DATA_W-1:0] lsu_wdata_i;
  logic [`BUS_STRB_W-1:0] lsu_wstrb_i;
  logic                   lsu_wvalid_i;
  logic                   lsu_wready_o;
  logic [1:0]             lsu_bresp_o;
  logic                   lsu_bvalid_o;
  logic                   lsu_bready_i;
  logic [`BUS_ADDR_W-1:0] m_araddr_o;
  logic                   m_arvalid_o;
  logic                   m_arready_i;
  logic [`BUS_DATA_W-1:0] m_rdata_i;
  logic [1:0]             m_rresp_i;
  logic                   m_rvalid_i;
  logic                   m_rready_o;
  logic [`BUS_ADDR_W-1:0] m_awaddr_o;
  logic                   m_awvalid_o;
  logic                   m_awready_i;
  logic [`BUS_DATA_W-1:0] m_wdata_o;
  logic [`BUS_STRB_W-1:0] m_wstrb_o;
  logic                   m_wvalid_o;
  logic                   m_wready_i;
  logic [1:0]             m_bresp_i;
  logic                   m_bvalid_i;
  logic                   m_bready_o;
  logic [7:0]             tx_data_o;
  logic                   tx_valid_o;

  // reference state
  logic [`BUS_DATA_W-1:0] shadow [logic [`BUS_ADDR_W-1:0]];
  logic [`BUS_DATA_W-1:0] ifu_exp;
  logic [`BUS_DATA_W-1:0] lsu_exp;
  logic [`BUS_DATA_W-1:0] rtc_last;
  logic [`BUS_ADDR_W-1:0] wr_addr;
  logic [`BUS_DATA_W-1:0] wr_data;
  logic [`BUS_STRB_W-1:0] wr_strb;
  logic                   lsu_exp_chk;
  logic                   rtc_low_chk;
  logic                   rtc_up_chk;
  logic                   uart_chk;
  logic                   race_chk;
  logic                   lsu_rd_done;
  int                     tx_pulses;
  int                     txn_done;
  int                     errors;

  bus_top DUT (.*);

  tb_mem_model u_mem (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (m_araddr_o),
    .arvalid_i (m_arvalid_o),
    .arready_o (m_arready_i),
    .rdata_o   (m_rdata_i),
    .rresp_o   (m_rresp_i),
    .rvalid_o  (m_rvalid_i),
    .rready_i  (m_rready_o),
    .awaddr_i  (m_awaddr_o),
    .awvalid_i (m_awvalid_o),
    .awready_o (m_awready_i),
    .wdata_i   (m_wdata_o),
    .wstrb_i   (m_wstrb_o),
    .wvalid_i  (m_wvalid_o),
    .wready_o  (m_wready_i),
    .bresp_o   (m_bresp_i),
    .bvalid_o  (m_bvalid_i),
    .bready_i  (m_bready_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_check(input string msg);
    errors++;
    $display("Fail at %0d ns: %s", $time, msg);
  endtask

  // same fill rule as the memory holds before any write
  function automatic logic [`BUS_DATA_W-1:0] expected_word(input logic [`BUS_ADDR_W-1:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return (addr ^ 32'hc3a5_5a3c) + {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [`BUS_DATA_W-1:0] merge_bytes(input logic [`BUS_DATA_W-1:0] old_w,
                                                        input logic [`BUS_DATA_W-1:0] new_w,
                                                        input logic [`BUS_STRB_W-1:0] strb);
    logic [`BUS_DATA_W-1:0] res;
    for (int b = 0; b < `BUS_STRB_W; b++) begin
      res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [`BUS_ADDR_W-1:0] rand_addr();
    return 32'h0000_1000 + ($urandom_range(63, 0) << 2);
  endfunction

  // hold is the number of cycles rready stays low once rvalid is seen
  task automatic ifu_read(input logic [`BUS_ADDR_W-1:0] addr, input int hold);
    @(posedge clk);
    #1;
    ifu_exp       = expected_word(addr);
    ifu_araddr_i  = addr;
    ifu_arvalid_i = 1'b1;
    do @(negedge clk); while (!ifu_arready_o);
    @(posedge clk);
    #1 ifu_arvalid_i = 1'b0;
    do @(negedge clk); while (!ifu_rvalid_o);
    repeat (hold) @(negedge clk);
    @(posedge clk);
    #1 ifu_rready_i = 1'b1;
    @(posedge clk);
    #1 ifu_rready_i = 1'b0;
    txn_done++;
  endtask

  task automatic lsu_read(input logic [`BUS_ADDR_W-1:0] addr, input int hold);
    logic [`BUS_DATA_W-1:0] got;
    @(posedge clk);
    #1;
    rtc_low_chk   = (addr == `BUS_RTC_ADDR);
    rtc_up_chk    = (addr == `BUS_RTC_ADDR_UP);
    lsu_exp_chk   = !rtc_low_chk && !rtc_up_chk;
    lsu_exp       = expected_word(addr);
    lsu_araddr_i  = addr;
    lsu_arvalid_i = 1'b1;
    do @(negedge clk); while (!lsu_arready_o);
    @(posedge clk);
    #1 lsu_arvalid_i = 1'b0;
    do @(negedge clk); while (!lsu_rvalid_o);
    repeat (hold) @(negedge clk);
    got = lsu_rdata_o;
    @(posedge clk);
    #1 lsu_rready_i = 1'b1;
    @(posedge clk);
    #1 lsu_rready_i = 1'b0;
    if (rtc_low_chk) begin
      rtc_last = got;
    end
    rtc_low_chk = 1'b0;
    rtc_up_chk  = 1'b0;
    lsu_exp_chk = 1'b0;
    lsu_rd_done = 1'b1;
    txn_done++;
  endtask

  task automatic lsu_write(input logic [`BUS_ADDR_W-1:0] addr, input logic [`BUS_DATA_W-1:0] data,
                           input logic [`BUS_STRB_W-1:0] strb, input int hold);
    @(posedge clk);
    #1;
    wr_addr       = addr;
    wr_data       = data;
    wr_strb       = strb;
    uart_chk      = (addr == `BUS_SERIAL_ADDR);
    lsu_awaddr_i  = addr;
    lsu_wdata_i   = data;
    lsu_wstrb_i   = strb;
    lsu_awvalid_i = 1'b1;
    lsu_wvalid_i  = 1'b1;
    do @(negedge clk); while (!(lsu_awready_o && lsu_wready_o));
    @(posedge clk);
    #1;
    lsu_awvalid_i = 1'b0;
    lsu_wvalid_i  = 1'b0;
    if (!uart_chk) begin
      shadow[addr] = merge_bytes(expected_word(addr), data, strb);
    end
    do @(negedge clk); while (!lsu_bvalid_o);
    repeat (hold) @(negedge clk);
    @(posedge clk);
    #1 lsu_bready_i = 1'b1;
    @(posedge clk);
    #1 lsu_bready_i = 1'b0;
    uart_chk = 1'b0;
    txn_done++;
  endtask

  // strobe lasts one cycle, so one negedge per pulse
  always @(negedge clk) begin
    if (rst) begin
      tx_pulses <= 0;
    end else if (tx_valid_o) begin
      tx_pulses <= tx_pulses + 1;
    end
  end

  a_ifu_data: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o |-> (ifu_rresp_o == OKAY) && (ifu_rdata_o == ifu_exp))
    else fail_check("fetch read data or response wrong");
  a_lsu_resp: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o |-> (lsu_rresp_o == OKAY))
    else fail_check("load response is not OKAY");
  a_lsu_data: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o && lsu_exp_chk |-> (lsu_rdata_o == lsu_exp))
    else fail_check("load data differs from merged shadow word");
  a_rtc_low: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o && rtc_low_chk |-> (lsu_rdata_o > rtc_last))
    else fail_check("timer low word did not increase");
  a_rtc_up: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o && rtc_up_chk |-> (lsu_rdata_o == 0))
    else fail_check("timer high word not zero early in run");
  a_no_ext_rtc: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o |-> (m_araddr_o != `BUS_RTC_ADDR) && (m_araddr_o != `BUS_RTC_ADDR_UP))
    else fail_check("timer read leaked to external port");
  a_ext_write: assert property (@(posedge clk) disable iff (rst)
    m_awvalid_o || m_wvalid_o |-> !uart_chk && (m_awaddr_o == wr_addr) &&
                                  (m_wdata_o == wr_data) && (m_wstrb_o == wr_strb))
    else fail_check("external write fields wrong or serial write leaked");
  a_tx_data: assert property (@(posedge clk) disable iff (rst)
    tx_valid_o |-> uart_chk && (tx_data_o == wr_data[7:0]))
    else fail_check("serial strobe with wrong byte or unexpected");
  a_tx_pulse: assert property (@(posedge clk) disable iff (rst)
    tx_valid_o |=> !tx_valid_o)
    else fail_check("serial strobe longer than one cycle");
  a_bresp: assert property (@(posedge clk) disable iff (rst)
    lsu_bvalid_o |-> (lsu_bresp_o == OKAY))
    else fail_check("write response is not OKAY");
  a_ifu_alone: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o |-> !lsu_rvalid_o && !lsu_bvalid_o && !lsu_arready_o && !lsu_awready_o &&
                     !lsu_wready_o)
    else fail_check("LSU active while fetch response pending");
  a_lsu_alone: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o || lsu_bvalid_o |-> !ifu_rvalid_o && !ifu_arready_o)
    else fail_check("fetch active while LSU response pending");
  a_race_order: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o && race_chk |-> lsu_rd_done)
    else fail_check("fetch response came before pending load finished");
  a_ifu_hold: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o && !ifu_rready_i |=> ifu_rvalid_o && $stable(ifu_rdata_o))
    else fail_check("fetch response changed under back-pressure");
  a_lsu_r_hold: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o && !lsu_rready_i |=> lsu_rvalid_o && $stable(lsu_rdata_o))
    else fail_check("load response changed under back-pressure");
  a_lsu_b_hold: assert property (@(posedge clk) disable iff (rst)
    lsu_bvalid_o && !lsu_bready_i |=> lsu_bvalid_o && $stable(lsu_bresp_o))
    else fail_check("write response changed under back-pressure");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: bus transactions did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [`BUS_ADDR_W-1:0] addr;
    void'($urandom(68313));
    {ifu_araddr_i, ifu_arvalid_i, ifu_rready_i} = '0;
    {lsu_araddr_i, lsu_arvalid_i, lsu_rready_i} = '0;
    {lsu_awaddr_i, lsu_awvalid_i, lsu_wdata_i, lsu_wstrb_i} = '0;
    {lsu_wvalid_i, lsu_bready_i} = '0;
    {ifu_exp, lsu_exp, rtc_last, wr_addr, wr_data, wr_strb} = '0;
    {lsu_exp_chk, rtc_low_chk, rtc_up_chk, uart_chk, race_chk, lsu_rd_done} = '0;
    txn_done = 0;
    errors   = 0;
    rst      = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;

    // high timer word right after reset
    lsu_read(`BUS_RTC_ADDR_UP, 0);
    for (int i = 0; i < 4; i++) begin
      ifu_read(rand_addr(), i % 2);
    end
    // partial stores, each read back
    for (int i = 0; i < 4; i++) begin
      addr = rand_addr();
      lsu_write(addr, $urandom(), 4'($urandom_range(14, 1)), 0);
      lsu_read(addr, 0);
    end
    lsu_write(`BUS_SERIAL_ADDR, $urandom(), 4'b0001, 0);
    assert (tx_pulses == 1) else fail_check("serial write did not give exactly one strobe");
    for (int i = 0; i < 3; i++) begin
      lsu_read(`BUS_RTC_ADDR, i);
    end
    // same-cycle requests, load wins and is held off a while
    race_chk    = 1'b1;
    lsu_rd_done = 1'b0;
    fork
      ifu_read(rand_addr(), 2);
      lsu_read(rand_addr(), 5);
    join
    race_chk = 1'b0;
    fork
      lsu_write(32'h0000_2000, $urandom(), 4'b1111, 5);
      ifu_read(32'h0000_2040, 3);
    join
    lsu_read(32'h0000_2000, 4);

    $display("checked %0d transactions, %0d errors", txn_done, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
logic/bus_pkg.sv
logic/dev_pkg.sv
logic/bus_rd_if.sv
logic/bus_wr_if.sv
logic/bus_arbiter_fsm.sv
logic/bus_clint.sv
logic/bus_uart_tx.sv
logic/bus_xbar.sv
logic/bus_top.sv
testbench/tb_mem_model.sv
testbench/tb_bus_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_bus_top -f files.f -o sim_bus_top || exit 1
out=$(./obj_dir/sim_bus_top)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
